// ==== hdl/ctrl_pkg.sv ====
package ctrl_pkg;

  // Host command that writes the radio configuration
  localparam logic [5:0] CFG_ADDR = 6'h09;

  // Field positions inside the configuration data word
  localparam int CFG_VNA_BIT    = 23;
  localparam int CFG_PA_EN_BIT  = 19;
  localparam int CFG_TR_DIS_BIT = 18;

  localparam logic [6:0] STATUS_ID = 7'b0001111;  // Slot 0 signature

  typedef struct packed {
    logic [5:0]  addr;
    logic [31:0] data;
    logic        ptt;
    logic        requires_resp;  // Host expects an echo
  } cmd_t;

  typedef struct packed {
    logic vna;         // Network analyzer mode
    logic pa_enable;
    logic tr_disable;
    logic int_ptt;     // PTT from the host
  } radio_cfg_t;

  // Debounced contacts, active high
  typedef struct packed {
    logic cwkey;
    logic ptt;
    logic txinhibit;
  } ext_keys_t;

  typedef struct packed {
    logic pa_tr;
    logic pa_en;
    logic env_pa;
    logic rfsw_sel;
  } pa_ctrl_t;

  typedef struct packed {
    logic [11:0] fwd_pwr;
    logic [11:0] rev_pwr;
    logic [11:0] bias_current;
    logic [11:0] temperature;
  } telemetry_t;

  typedef logic [39:0] resp_word_t;

endpackage

// ==== hdl/input_debounce.sv ====
`timescale 1ns/100ps

module input_debounce #(
  parameter int DEBOUNCE_CYCLES = 16
) (
  input  logic clk,
  input  logic arst_n_i,
  input  logic raw_i,
  output logic clean_o
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [1:0]       sync_q;   // Metastability guard
  logic             level_q;  // Last synchronized sample
  logic [CNT_W-1:0] cnt_q;
  logic             clean_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], raw_i};
    end
  end

  // Any change restarts the stability window
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      level_q <= 1'b0;
      cnt_q   <= '0;
      clean_q <= 1'b0;
    end else begin
      level_q <= sync_q[1];
      if (sync_q[1] != level_q) begin
        cnt_q <= CNT_W'(DEBOUNCE_CYCLES - 1);
      end else if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end else begin
        clean_q <= level_q;  // Window expired, level is stable
      end
    end
  end

  assign clean_o = clean_q;

endmodule

// ==== hdl/cmd_decode.sv ====
`timescale 1ns/100ps

module cmd_decode
  import ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n_i,
  input  cmd_t       cmd_i,
  input  logic       cmd_rqst_i,
  output radio_cfg_t cfg_o,
  output cmd_t       held_cmd_o,
  output logic       resp_pend_o,
  input  logic       resp_taken_i
);

  radio_cfg_t cfg_q;
  cmd_t       held_q;
  logic       pend_q;
  logic       new_resp;

  assign new_resp = cmd_rqst_i & cmd_i.requires_resp;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q <= '0;
    end else if (cmd_rqst_i) begin
      cfg_q.int_ptt <= cmd_i.ptt;  // Follows every command
      if (cmd_i.addr == CFG_ADDR) begin
        cfg_q.vna        <= cmd_i.data[CFG_VNA_BIT];
        cfg_q.pa_enable  <= cmd_i.data[CFG_PA_EN_BIT];
        cfg_q.tr_disable <= cmd_i.data[CFG_TR_DIS_BIT];
      end
    end
  end

  // One-deep response queue, a newer command wins
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= 1'b0;
    end else if (new_resp) begin
      pend_q <= 1'b1;
    end else if (resp_taken_i) begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (new_resp) held_q <= cmd_i;
  end

  assign cfg_o       = cfg_q;
  assign held_cmd_o  = held_q;
  assign resp_pend_o = pend_q;

endmodule

// ==== hdl/tx_keying.sv ====
`timescale 1ns/100ps

module tx_keying
  import ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n_i,
  input  radio_cfg_t cfg_i,
  input  ext_keys_t  keys_i,
  input  logic       run_i,
  output logic       tx_on_o,
  output pa_ctrl_t   pa_o
);

  logic     tx_on_d;
  logic     tx_on_q;
  logic     pa_path;  // Amplifier in the signal path
  pa_ctrl_t pa_d;
  pa_ctrl_t pa_q;

  always_comb begin
    tx_on_d = (cfg_i.int_ptt | keys_i.cwkey | keys_i.ptt) & ~keys_i.txinhibit & run_i;
    pa_path = ~cfg_i.vna & cfg_i.pa_enable;

    pa_d.pa_tr    = tx_on_d & ~cfg_i.vna & (cfg_i.pa_enable | ~cfg_i.tr_disable);
    pa_d.pa_en    = tx_on_d & pa_path;
    pa_d.env_pa   = tx_on_d;
    pa_d.rfsw_sel = pa_path;  // Independent of keying
  end

  // Keying and PA controls change on the same edge
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_on_q <= 1'b0;
      pa_q    <= '0;
    end else begin
      tx_on_q <= tx_on_d;
      pa_q    <= pa_d;
    end
  end

  assign tx_on_o = tx_on_q;
  assign pa_o    = pa_q;

endmodule

// ==== hdl/led_status.sv ====
`timescale 1ns/100ps

module led_status #(
  parameter int LED_TICK_BITS = 17
) (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic [3:0] events_i,
  output logic [3:0] led_n_o
);

  typedef enum logic [1:0] {
    ST_CLR   = 2'b00,
    ST_SET   = 2'b01,
    ST_WAIT1 = 2'b10,
    ST_WAIT2 = 2'b11
  } flash_state_e;

  logic [LED_TICK_BITS-1:0] tick_cnt_q;
  logic                     tick;
  flash_state_e             state_q [4];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) tick_cnt_q <= '0;
    else           tick_cnt_q <= tick_cnt_q + 1'b1;
  end

  assign tick = &tick_cnt_q;  // Once per counter wrap

  // LED stays lit for 2 to 3 tick periods
  for (genvar i = 0; i < 4; i++) begin : g_flash
    always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        state_q[i] <= ST_CLR;
      end else begin
        case (state_q[i])
          ST_CLR:   if (events_i[i]) state_q[i] <= ST_SET;
          ST_SET:   if (tick) state_q[i] <= ST_WAIT1;
          ST_WAIT1: if (tick) state_q[i] <= ST_WAIT2;
          default:  if (tick) state_q[i] <= ST_CLR;
        endcase
      end
    end

    assign led_n_o[i] = (state_q[i] == ST_CLR);  // Active low, off when idle
  end

endmodule

// ==== hdl/resp_builder.sv ====
`timescale 1ns/100ps

module resp_builder
  import ctrl_pkg::*;
#(
  parameter logic [7:0] SERIAL_NO = 8'h00
) (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       resp_rqst_i,
  input  cmd_t       held_cmd_i,
  input  logic       resp_pend_i,
  output logic       resp_taken_o,
  input  logic       tx_on_i,
  input  ext_keys_t  keys_i,
  input  logic       rx_activity_i,
  input  telemetry_t telem_i,
  output resp_word_t resp_o
);

  typedef enum logic {
    SEL_STATUS = 1'b0,
    SEL_ECHO   = 1'b1
  } resp_sel_e;

  logic [1:0]  slot_q;
  resp_word_t  resp_q;
  resp_sel_e   sel;
  logic [31:0] payload;
  resp_word_t  status_word;
  resp_word_t  echo_word;

  // A queued echo takes precedence over the status rotation
  assign sel          = resp_pend_i ? SEL_ECHO : SEL_STATUS;
  assign resp_taken_o = resp_rqst_i & (sel == SEL_ECHO);

  always_comb begin
    case (slot_q)
      2'd0:    payload = {STATUS_ID, rx_activity_i, 8'h00, 8'h00, SERIAL_NO};
      2'd1:    payload = {4'h0, telem_i.temperature, 4'h0, telem_i.fwd_pwr};
      2'd2:    payload = {4'h0, telem_i.rev_pwr, 4'h0, telem_i.bias_current};
      default: payload = 32'h0000_0000;  // Spare slot
    endcase
  end

  assign status_word = {3'b000, slot_q, 1'b0, keys_i.cwkey, keys_i.ptt, payload};
  assign echo_word   = {1'b1, held_cmd_i.addr, tx_on_i, held_cmd_i.data};

  // Slot rotator, an echo also consumes a slot
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      slot_q <= 2'd0;
    end else if (resp_rqst_i) begin
      slot_q <= slot_q + 2'd1;
    end
  end

  // Word register, held between requests
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_q <= {32'h0000_0000, SERIAL_NO};
    end else if (resp_rqst_i) begin
      case (sel)
        SEL_ECHO: resp_q <= echo_word;
        default:  resp_q <= status_word;
      endcase
    end
  end

  assign resp_o = resp_q;

endmodule

// ==== hdl/radio_ctrl_top.sv ====
`timescale 1ns/100ps

module radio_ctrl_top
  import ctrl_pkg::*;
#(
  parameter logic [7:0] SERIAL_NO       = 8'h00,
  parameter int         DEBOUNCE_CYCLES = 16,
  parameter int         LED_TICK_BITS   = 17
) (
  input  logic       clk,
  input  logic       arst_n_i,
  input  cmd_t       cmd_i,
  input  logic       cmd_rqst_i,
  input  logic       run_i,
  input  logic       cwkey_n_i,
  input  logic       ptt_n_i,
  input  logic       txinhibit_n_i,
  input  logic       rx_good_lvl_i,
  input  logic       rx_clip_i,
  input  telemetry_t telem_i,
  input  logic       resp_rqst_i,
  output logic       tx_on_o,
  output logic       cw_keydown_o,
  output pa_ctrl_t   pa_o,
  output logic [3:0] led_n_o,  // Run, tx, good level, clip
  output resp_word_t resp_o,
  output logic       cmd_resp_pend_o
);

  radio_cfg_t cfg;
  cmd_t       held_cmd;
  logic       resp_pend;
  logic       resp_taken;
  ext_keys_t  keys;
  logic       tx_on;
  logic [3:0] led_n;
  logic       rx_activity;

  cmd_decode cmd_decode_i (
    .clk, .arst_n_i, .cmd_i, .cmd_rqst_i,
    .cfg_o(cfg), .held_cmd_o(held_cmd),
    .resp_pend_o(resp_pend), .resp_taken_i(resp_taken)
  );

  // Contacts are active low at the connector
  input_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb_cwkey_i (
    .clk, .arst_n_i, .raw_i(~cwkey_n_i), .clean_o(keys.cwkey));
  input_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb_ptt_i (
    .clk, .arst_n_i, .raw_i(~ptt_n_i), .clean_o(keys.ptt));
  input_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) deb_txinhibit_i (
    .clk, .arst_n_i, .raw_i(~txinhibit_n_i), .clean_o(keys.txinhibit));

  tx_keying tx_keying_i (
    .clk, .arst_n_i, .cfg_i(cfg), .keys_i(keys), .run_i,
    .tx_on_o(tx_on), .pa_o
  );

  led_status #(.LED_TICK_BITS(LED_TICK_BITS)) led_status_i (
    .clk, .arst_n_i,
    .events_i({run_i, tx_on, rx_good_lvl_i, rx_clip_i}),
    .led_n_o(led_n)
  );

  assign rx_activity = ~led_n[1] | ~led_n[0];  // Either receive LED lit

  resp_builder #(.SERIAL_NO(SERIAL_NO)) resp_builder_i (
    .clk, .arst_n_i, .resp_rqst_i,
    .held_cmd_i(held_cmd), .resp_pend_i(resp_pend), .resp_taken_o(resp_taken),
    .tx_on_i(tx_on), .keys_i(keys), .rx_activity_i(rx_activity),
    .telem_i, .resp_o
  );

  assign tx_on_o         = tx_on;
  assign cw_keydown_o    = keys.cwkey;
  assign led_n_o         = led_n;
  assign cmd_resp_pend_o = resp_pend;  // Lets the host poll for an echo

endmodule

// ==== verif/radio_ctrl_chk.sv ====
`timescale 1ns/100ps

module radio_ctrl_chk
  import ctrl_pkg::*;
(
  input logic       clk,
  input logic       arst_n_i,
  input logic       resp_rqst_i,
  input logic       tx_on_i,
  input pa_ctrl_t   pa_i,
  input logic [3:0] led_n_i,
  input resp_word_t resp_i
);

  // PA bias only while transmitting
  a_pa_en_needs_tx: assert property (
    @(posedge clk) disable iff (!arst_n_i) pa_i.pa_en |-> tx_on_i
  ) else $error("pa_en high without tx_on");

  a_leds_off_in_reset: assert property (
    @(posedge clk) !arst_n_i |-> (led_n_i == 4'hF)
  ) else $error("LED lit during reset");

  a_resp_held: assert property (
    @(posedge clk) disable iff (!arst_n_i) !$past(resp_rqst_i) |-> $stable(resp_i)
  ) else $error("resp_o changed without a request");  // Word only moves after a strobe

endmodule

bind radio_ctrl_top radio_ctrl_chk radio_ctrl_chk_i (
  .clk(clk), .arst_n_i(arst_n_i), .resp_rqst_i(resp_rqst_i), .tx_on_i(tx_on_o),
  .pa_i(pa_o), .led_n_i(led_n_o), .resp_i(resp_o)
);

// ==== verif/radio_ctrl_tb.sv ====
`timescale 1ns/100ps

module radio_ctrl_tb
  import ctrl_pkg::*;
();

  localparam int         CLK_PERIOD      = 4;
  localparam int         DEBOUNCE_CYCLES = 4;
  localparam int         LED_TICK_BITS   = 3;
  localparam logic [7:0] SERIAL_NO       = 8'h5A;
  localparam int         NUM_ENTRIES     = 10;
  localparam int         WATCHDOG_CYCLES = NUM_ENTRIES * 3 * (2 ** LED_TICK_BITS) + 200;

  // Table row with contacts active high
  typedef struct packed {
    logic [5:0] addr;
    logic       ptt;
    logic       vna;
    logic       pa_enable;
    logic       tr_disable;
    logic       cwkey;
    logic       ptt_key;
    logic       txinhibit;
    logic       run;
    logic       tx_on;
    pa_ctrl_t   pa;
  } stim_t;

  logic       clk = 1'b0;
  logic       arst_n_i, cmd_rqst_i, run_i, resp_rqst_i;
  logic       cwkey_n_i, ptt_n_i, txinhibit_n_i, rx_good_lvl_i, rx_clip_i;
  cmd_t       cmd_i;
  telemetry_t telem_i;
  logic       tx_on_o, cw_keydown_o, cmd_resp_pend_o;
  pa_ctrl_t   pa_o;
  logic [3:0] led_n_o;
  resp_word_t resp_o;

  stim_t       stim_table [NUM_ENTRIES];
  logic [31:0] lcg_state = 32'd91;
  logic [31:0] cmd_data;

  radio_ctrl_top #(
    .SERIAL_NO(SERIAL_NO), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .LED_TICK_BITS(LED_TICK_BITS)
  ) radio_ctrl_top_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [39:0] got, input logic [39:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic send_command(input cmd_t cmd);
    @(posedge clk);
    cmd_i      <= cmd;
    cmd_rqst_i <= 1'b1;
    @(posedge clk);
    cmd_rqst_i <= 1'b0;
  endtask

  // Word is checked one cycle after the strobe
  task automatic request_response(input string name, input resp_word_t exp);
    @(posedge clk);
    resp_rqst_i <= 1'b1;
    @(posedge clk);
    resp_rqst_i <= 1'b0;
    @(negedge clk);
    check_value(name, resp_o, exp);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, the test sequence did not finish", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $fatal(1);
  end

  initial begin
    arst_n_i = 1'b1;
    {cmd_rqst_i, run_i, resp_rqst_i, rx_good_lvl_i, rx_clip_i} = '0;
    {cwkey_n_i, ptt_n_i, txinhibit_n_i} = 3'b111;  // Contacts open
    cmd_i   = '0;
    telem_i = '0;
    //              addr   ptt,vna,pen,trd  cw,ptt,inh,run  tx    pa_tr,pa_en,env,rfsw
    stim_table[0] = {6'h09, 4'b1010, 4'b0001, 1'b1, 4'b1111};
    stim_table[1] = {6'h09, 4'b0010, 4'b0001, 1'b0, 4'b0001};
    stim_table[2] = {6'h09, 4'b0001, 4'b1001, 1'b1, 4'b0010};
    stim_table[3] = {6'h09, 4'b0000, 4'b0101, 1'b1, 4'b1010};
    stim_table[4] = {6'h09, 4'b0110, 4'b0101, 1'b1, 4'b0010};
    stim_table[5] = {6'h12, 4'b1010, 4'b0001, 1'b1, 4'b0010};  // Only ptt taken
    stim_table[6] = {6'h09, 4'b1011, 4'b0011, 1'b0, 4'b0001};
    stim_table[7] = {6'h09, 4'b1011, 4'b1000, 1'b0, 4'b0001};
    stim_table[8] = {6'h09, 4'b0011, 4'b1101, 1'b1, 4'b1111};
    stim_table[9] = {6'h2A, 4'b0100, 4'b0001, 1'b0, 4'b0001};
    #1 arst_n_i = 1'b0;
    repeat (4) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);
    check_value("resp_o", resp_o, {32'h0, SERIAL_NO});
    check_value("led_n_o", led_n_o, 4'hF);
    check_value("pa_o", pa_o, 4'h0);
    check_value("tx_on_o", tx_on_o, 1'b0);
    check_value("cmd_resp_pend_o", cmd_resp_pend_o, 1'b0);
    @(posedge clk);
    cmd_data = next_random();
    telem_i <= {next_random(), cmd_data[15:0]};

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      @(posedge clk);
      cwkey_n_i     <= ~stim_table[i].cwkey;
      ptt_n_i       <= ~stim_table[i].ptt_key;
      txinhibit_n_i <= ~stim_table[i].txinhibit;
      run_i         <= stim_table[i].run;
      cmd_data = next_random();
      cmd_data[CFG_VNA_BIT]    = stim_table[i].vna;
      cmd_data[CFG_PA_EN_BIT]  = stim_table[i].pa_enable;
      cmd_data[CFG_TR_DIS_BIT] = stim_table[i].tr_disable;
      send_command({stim_table[i].addr, cmd_data, stim_table[i].ptt, 1'b0});
      @(posedge clk);
      @(negedge clk);
      check_value("pa_o.rfsw_sel", pa_o.rfsw_sel, stim_table[i].pa.rfsw_sel);
      repeat (DEBOUNCE_CYCLES + 6) @(negedge clk);
      check_value("tx_on_o", tx_on_o, stim_table[i].tx_on);
      check_value("pa_o", pa_o, stim_table[i].pa);
    end

    @(posedge clk);
    cwkey_n_i <= 1'b0;  // Glitch one cycle short of the window
    repeat (DEBOUNCE_CYCLES - 1) @(posedge clk);
    cwkey_n_i <= 1'b1;
    repeat (DEBOUNCE_CYCLES + 8) begin
      @(negedge clk);
      check_value("cw_keydown_o", cw_keydown_o, 1'b0);
    end
    @(posedge clk);
    cwkey_n_i <= 1'b0;
    repeat (DEBOUNCE_CYCLES + 6) @(negedge clk);
    check_value("cw_keydown_o", cw_keydown_o, 1'b1);

    // Key bits are cwkey down, ptt up
    request_response("resp_o", {5'b00000, 3'b010, 7'b0001111, 1'b0, 16'h0, SERIAL_NO});
    request_response("resp_o", {5'b00001, 3'b010, 4'h0, telem_i.temperature,
                                4'h0, telem_i.fwd_pwr});
    request_response("resp_o", {5'b00010, 3'b010, 4'h0, telem_i.rev_pwr,
                                4'h0, telem_i.bias_current});
    request_response("resp_o", {5'b00011, 3'b010, 32'h0});

    cmd_data = next_random();
    send_command({6'h15, cmd_data, 1'b0, 1'b1});
    @(negedge clk);
    check_value("cmd_resp_pend_o", cmd_resp_pend_o, 1'b1);
    request_response("resp_o", {1'b1, 6'h15, 1'b1, cmd_data});  // Keyed by cwkey
    check_value("cmd_resp_pend_o", cmd_resp_pend_o, 1'b0);
    request_response("resp_o", {5'b00001, 3'b010, 4'h0, telem_i.temperature,
                                4'h0, telem_i.fwd_pwr});

    @(posedge clk);
    rx_clip_i <= 1'b1;
    @(posedge clk);
    rx_clip_i <= 1'b0;
    @(negedge clk);
    check_value("led_n_o[0]", led_n_o[0], 1'b0);
    // Lit clip LED shows up as receive activity in slot 0
    request_response("resp_o", {5'b00010, 3'b010, 4'h0, telem_i.rev_pwr,
                                4'h0, telem_i.bias_current});
    request_response("resp_o", {5'b00011, 3'b010, 32'h0});
    request_response("resp_o", {5'b00000, 3'b010, 7'b0001111, 1'b1, 16'h0, SERIAL_NO});
    repeat (2 * (2 ** LED_TICK_BITS) - 7) @(negedge clk);  // Three requests took six cycles
    check_value("led_n_o[0]", led_n_o[0], 1'b0);  // Still lit after two ticks
    repeat ((2 ** LED_TICK_BITS) + 2) @(negedge clk);
    check_value("led_n_o[0]", led_n_o[0], 1'b1);

    $display("Test OK");
    $finish;
  end

endmodule

// ==== vlog.f ====
hdl/ctrl_pkg.sv
hdl/input_debounce.sv
hdl/cmd_decode.sv
hdl/tx_keying.sv
hdl/led_status.sv
hdl/resp_builder.sv
hdl/radio_ctrl_top.sv
verif/radio_ctrl_chk.sv
verif/radio_ctrl_tb.sv
